// ==== lidar_config.svh ====
`ifndef LIDAR_CONFIG_SVH
`define LIDAR_CONFIG_SVH

// clocks per serial bit at the default baud rate
`define LIDAR_CLKS_PER_BIT 868

// packet sync bytes
`define LIDAR_HEADER_A 8'h55
`define LIDAR_HEADER_B 8'hAA

// samples below this distance count as an obstacle
`define LIDAR_OBS_DISTANCE 16'h0400

// leading samples that feed the obstacle bitmap
`define LIDAR_ALERT_SAMPLES 16

// one divider iteration per numerator bit
`define LIDAR_DIV_STEPS 32

`endif

// ==== lidar_pkg.sv ====
`default_nettype none

package lidar_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  count_t;
    typedef logic [15:0] dist_t;
    typedef logic [15:0] angle_t;
    typedef logic [31:0] prod_t;
    typedef logic [15:0] alert_t;

    // packet parser states, in field order
    typedef enum logic [3:0] {
        HUNT_A, HUNT_B, GET_CT,
        GET_FSA_LO, GET_FSA_HI, GET_LSA_LO, GET_LSA_HI,
        GET_LO, GET_HI,
        DIV_MIN, DIV_MAX, REPORT
    } pkt_state_e;

endpackage

`default_nettype wire

// ==== scan_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// samples from the parser to the statistics block
interface sample_if
    import lidar_pkg::*;
();
    logic   scan_clear;
    logic   sample_valid;
    dist_t  sample;
    count_t sample_index;

    modport fsm   (output scan_clear, sample_valid, sample, sample_index);
    modport stats (input  scan_clear, sample_valid, sample, sample_index);
endinterface

// division requests from the parser to the shared divider
interface div_if
    import lidar_pkg::*;
();
    logic   start;
    prod_t  numerator;
    count_t denominator;
    logic   busy;
    logic   done;
    angle_t quotient;

    modport fsm (output start, numerator, denominator, input  busy, done, quotient);
    modport div (input  start, numerator, denominator, output busy, done, quotient);
endinterface

`default_nettype wire

// ==== baud_timer.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "lidar_config.svh"

module baud_timer #(
    parameter int CLKS_PER_BIT = `LIDAR_CLKS_PER_BIT
) (
    input  logic clk,
    input  logic TxD_reset,
    input  logic bit_start,
    input  logic bit_enable,
    output logic sample_tick
);

    localparam int CW = $clog2(CLKS_PER_BIT);

    logic [CW-1:0] count;

    assign sample_tick = bit_enable && (count == '0);

    always_ff @(posedge clk) begin
        if (TxD_reset) begin
            count <= '0;
        end else if (bit_start) begin
            // first tick lands in the middle of the start bit
            count <= CW'(CLKS_PER_BIT / 2 - 1);
        end else if (bit_enable) begin
            if (count == '0) begin
                count <= CW'(CLKS_PER_BIT - 1);
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "lidar_config.svh"

module uart_rx
    import lidar_pkg::*;
#(
    parameter int CLKS_PER_BIT = `LIDAR_CLKS_PER_BIT
) (
    input  logic  clk,
    input  logic  TxD_reset,
    input  logic  serial_in,
    output byte_t byte_data,
    output logic  byte_valid
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_phase_e;

    rx_phase_e  phase;
    logic       rx_meta;
    logic       rx_sync;
    logic [2:0] bit_cnt;
    logic       bit_start;
    logic       bit_enable;
    logic       sample_tick;

    // falling edge on an idle line
    assign bit_start  = (phase == RX_IDLE) && !rx_sync;
    assign bit_enable = (phase != RX_IDLE);

    baud_timer #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_baud_timer (
        .clk        (clk),
        .TxD_reset  (TxD_reset),
        .bit_start  (bit_start),
        .bit_enable (bit_enable),
        .sample_tick(sample_tick)
    );

    // line idles high
    always_ff @(posedge clk) begin
        if (TxD_reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= serial_in;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (TxD_reset) begin
            phase      <= RX_IDLE;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (phase)
                RX_IDLE: begin
                    if (bit_start) begin
                        phase <= RX_START;
                    end
                end
                RX_START: begin
                    // line back high at mid start bit means a glitch
                    if (sample_tick) begin
                        phase   <= rx_sync ? RX_IDLE : RX_DATA;
                        bit_cnt <= '0;
                    end
                end
                RX_DATA: begin
                    if (sample_tick) begin
                        // lsb first
                        byte_data <= {rx_sync, byte_data[7:1]};
                        bit_cnt   <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            phase <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (sample_tick) begin
                        byte_valid <= rx_sync;
                        phase      <= RX_IDLE;
                    end
                end
                default: phase <= RX_IDLE;
            endcase
        end
    end

    // a whole frame separates two bytes
    a_single_byte_strobe: assert property (
        @(posedge clk) disable iff (TxD_reset) byte_valid |=> !byte_valid
    );

endmodule

`default_nettype wire

// ==== packet_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "lidar_config.svh"

module packet_fsm
    import lidar_pkg::*;
(
    input  logic   clk,
    input  logic   TxD_reset,
    input  byte_t  byte_data,
    input  logic   byte_valid,
    input  count_t min_index,
    input  count_t max_index,
    sample_if.fsm  sample_bus,
    div_if.fsm     div_bus,
    output logic   result_valid,
    output angle_t min_angle,
    output angle_t max_angle
);

    pkt_state_e state;
    count_t     ct;
    angle_t     fsa;
    angle_t     lsa;
    byte_t      lo_byte;
    count_t     idx;
    logic       div_launched;
    angle_t     span;
    angle_t     result_angle;
    count_t     pick_index;

    // scan span wraps at 16 bits
    assign span         = lsa - fsa;
    assign result_angle = fsa + div_bus.quotient;
    assign pick_index   = (state == DIV_MIN) ? min_index : max_index;
    assign result_valid = (state == REPORT);

    always_ff @(posedge clk) begin
        if (TxD_reset) begin
            state                   <= HUNT_A;
            idx                     <= '0;
            div_launched            <= 1'b0;
            sample_bus.scan_clear   <= 1'b0;
            sample_bus.sample_valid <= 1'b0;
            div_bus.start           <= 1'b0;
        end else begin
            sample_bus.scan_clear   <= 1'b0;
            sample_bus.sample_valid <= 1'b0;
            div_bus.start           <= 1'b0;
            case (state)
                DIV_MIN, DIV_MAX: begin
                    // hold off until the last sample has reached the statistics
                    if (!div_launched && !sample_bus.sample_valid && !div_bus.busy) begin
                        div_bus.start       <= 1'b1;
                        div_bus.numerator   <= prod_t'(pick_index) * prod_t'(span);
                        div_bus.denominator <= ct - count_t'(1);
                        div_launched        <= 1'b1;
                    end
                    if (div_bus.done) begin
                        div_launched <= 1'b0;
                        if (state == DIV_MIN) begin
                            min_angle <= result_angle;
                            state     <= DIV_MAX;
                        end else begin
                            max_angle <= result_angle;
                            state     <= REPORT;
                        end
                    end
                end
                REPORT: state <= HUNT_A;
                default: begin
                    if (byte_valid) begin
                        case (state)
                            HUNT_A: begin
                                if (byte_data == `LIDAR_HEADER_A) begin
                                    state <= HUNT_B;
                                end
                            end
                            HUNT_B: begin
                                // second sync byte must follow at once
                                if (byte_data == `LIDAR_HEADER_B) begin
                                    state                 <= GET_CT;
                                    sample_bus.scan_clear <= 1'b1;
                                end else begin
                                    state <= HUNT_A;
                                end
                            end
                            GET_CT: begin
                                // fewer than two samples gives no span
                                if (byte_data < count_t'(2)) begin
                                    state <= HUNT_A;
                                end else begin
                                    ct    <= byte_data;
                                    state <= GET_FSA_LO;
                                end
                            end
                            GET_FSA_LO: begin
                                lo_byte <= byte_data;
                                state   <= GET_FSA_HI;
                            end
                            GET_FSA_HI: begin
                                fsa   <= {byte_data, lo_byte};
                                state <= GET_LSA_LO;
                            end
                            GET_LSA_LO: begin
                                lo_byte <= byte_data;
                                state   <= GET_LSA_HI;
                            end
                            GET_LSA_HI: begin
                                lsa   <= {byte_data, lo_byte};
                                idx   <= '0;
                                state <= GET_LO;
                            end
                            GET_LO: begin
                                lo_byte <= byte_data;
                                state   <= GET_HI;
                            end
                            GET_HI: begin
                                sample_bus.sample       <= {byte_data, lo_byte};
                                sample_bus.sample_index <= idx;
                                sample_bus.sample_valid <= 1'b1;
                                idx                     <= idx + 1'b1;
                                state <= (idx == ct - count_t'(1)) ? DIV_MIN : GET_LO;
                            end
                            default: state <= HUNT_A;
                        endcase
                    end
                end
            endcase
        end
    end

    // the shared divider takes one request at a time
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (TxD_reset) div_bus.start |-> !div_bus.busy
    );

    a_result_one_cycle: assert property (
        @(posedge clk) disable iff (TxD_reset) result_valid |=> !result_valid
    );

endmodule

`default_nettype wire

// ==== scan_stats.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "lidar_config.svh"

module scan_stats
    import lidar_pkg::*;
(
    input  logic    clk,
    input  logic    TxD_reset,
    sample_if.stats sample_bus,
    output count_t  min_index,
    output count_t  max_index,
    output alert_t  alert_bits
);

    dist_t min_dist;
    dist_t max_dist;
    logic  use_sample;
    logic  near;

    // zero means no return
    assign use_sample = sample_bus.sample_valid && (sample_bus.sample != '0);
    assign near       = sample_bus.sample < dist_t'(`LIDAR_OBS_DISTANCE);

    always_ff @(posedge clk) begin
        if (TxD_reset || sample_bus.scan_clear) begin
            min_dist   <= '1;
            max_dist   <= '0;
            min_index  <= '0;
            max_index  <= '0;
            alert_bits <= '0;
        end else if (use_sample) begin
            // strict compares keep the earlier index on a tie
            if (sample_bus.sample < min_dist) begin
                min_dist  <= sample_bus.sample;
                min_index <= sample_bus.sample_index;
            end
            if (sample_bus.sample > max_dist) begin
                max_dist  <= sample_bus.sample;
                max_index <= sample_bus.sample_index;
            end
            if (sample_bus.sample_index < count_t'(`LIDAR_ALERT_SAMPLES)) begin
                alert_bits <= {near, alert_bits[$bits(alert_t)-1:1]};
            end
        end
    end

endmodule

`default_nettype wire

// ==== angle_divider.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "lidar_config.svh"

module angle_divider
    import lidar_pkg::*;
(
    input  logic clk,
    input  logic TxD_reset,
    div_if.div   div_bus
);

    localparam int CW = $clog2(`LIDAR_DIV_STEPS + 1);

    logic [CW-1:0]         steps_left;
    prod_t                 num_q;
    count_t                den_q;
    count_t                rem_q;
    angle_t                quo_q;
    logic [$bits(count_t):0] shifted;
    logic                  fits;

    // partial remainder stays below the denominator, so 8 bits hold it
    assign shifted          = {rem_q, num_q[$bits(prod_t)-1]};
    assign fits             = shifted >= {1'b0, den_q};
    assign div_bus.busy     = (steps_left != '0);
    assign div_bus.quotient = quo_q;

    always_ff @(posedge clk) begin
        if (TxD_reset) begin
            steps_left   <= '0;
            div_bus.done <= 1'b0;
        end else begin
            div_bus.done <= (steps_left == CW'(1));
            if (div_bus.start) begin
                steps_left <= CW'(`LIDAR_DIV_STEPS);
                num_q      <= div_bus.numerator;
                den_q      <= div_bus.denominator;
                rem_q      <= '0;
                quo_q      <= '0;
            end else if (div_bus.busy) begin
                steps_left <= steps_left - 1'b1;
                num_q      <= num_q << 1;
                rem_q      <= fits ? count_t'(shifted - {1'b0, den_q}) : shifted[7:0];
                // only the low quotient bits survive
                quo_q      <= {quo_q[$bits(angle_t)-2:0], fits};
            end
        end
    end

    a_nonzero_divisor: assert property (
        @(posedge clk) disable iff (TxD_reset) div_bus.start |-> (div_bus.denominator != '0)
    );

endmodule

`default_nettype wire

// ==== lidar_scan_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "lidar_config.svh"

module lidar_scan_top
    import lidar_pkg::*;
#(
    parameter int CLKS_PER_BIT = `LIDAR_CLKS_PER_BIT
) (
    input  logic   clk,
    input  logic   TxD_reset,
    input  logic   serial_in,
    output logic   result_valid,
    output angle_t min_angle,
    output angle_t max_angle,
    output alert_t obs_alert
);

    byte_t  byte_data;
    logic   byte_valid;
    count_t min_index;
    count_t max_index;

    sample_if sample_bus ();
    div_if    div_bus ();

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_rx (
        .clk       (clk),
        .TxD_reset (TxD_reset),
        .serial_in (serial_in),
        .byte_data (byte_data),
        .byte_valid(byte_valid)
    );

    packet_fsm u_packet_fsm (
        .clk         (clk),
        .TxD_reset   (TxD_reset),
        .byte_data   (byte_data),
        .byte_valid  (byte_valid),
        .min_index   (min_index),
        .max_index   (max_index),
        .sample_bus  (sample_bus.fsm),
        .div_bus     (div_bus.fsm),
        .result_valid(result_valid),
        .min_angle   (min_angle),
        .max_angle   (max_angle)
    );

    scan_stats u_scan_stats (
        .clk       (clk),
        .TxD_reset (TxD_reset),
        .sample_bus(sample_bus.stats),
        .min_index (min_index),
        .max_index (max_index),
        .alert_bits(obs_alert)
    );

    angle_divider u_angle_divider (
        .clk      (clk),
        .TxD_reset(TxD_reset),
        .div_bus  (div_bus.div)
    );

endmodule

`default_nettype wire

// ==== lidar_scan_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "lidar_config.svh"

module lidar_scan_tb
    import lidar_pkg::*;
();

    localparam int          TB_CLKS_PER_BIT = 16;
    localparam int          CLK_PERIOD      = 40;
    localparam int          CT_MAX          = 24;
    localparam int          NUM_PACKETS     = 14;
    localparam int          BURST_PACKETS   = 6;
    localparam logic [31:0] SEED            = 32'heeaf_5493;
    // bytes sent, bits per byte, clocks per bit, ns per clock, margin
    localparam longint WATCHDOG_NS = longint'(NUM_PACKETS) * longint'(7 + 2 * CT_MAX)
                                     * 10 * TB_CLKS_PER_BIT * CLK_PERIOD * 2;

    // zeros, ties on both extremes, near samples inside and beyond the alert window
    localparam dist_t FIXED_SAMPLES [20] = '{
        16'h0000, 16'h0800, 16'h0200, 16'h0000, 16'h0150,
        16'h9000, 16'h0150, 16'h0000, 16'h9000, 16'h03FF,
        16'h0400, 16'h2000, 16'h0300, 16'h0000, 16'h0390,
        16'h7000, 16'h1000, 16'h0180, 16'h0000, 16'h0160
    };

    // second sync byte wrong, and no 0x55 in the rest of it
    localparam byte_t BAD_HEADER_PKT [13] = '{
        8'h55, 8'h12, 8'h03, 8'h00, 8'h01, 8'h00, 8'h02,
        8'h00, 8'h03, 8'h01, 8'h03, 8'h02, 8'h03
    };

    logic   clk;
    logic   TxD_reset;
    logic   serial_in;
    logic   result_valid;
    angle_t min_angle;
    angle_t max_angle;
    alert_t obs_alert;

    dist_t      samples [CT_MAX];
    angle_t     exp_min_tab [16];
    angle_t     exp_max_tab [16];
    alert_t     exp_alert_tab [16];
    logic [3:0] expected_count;
    logic [3:0] results_seen;
    angle_t     exp_min;
    angle_t     exp_max;
    alert_t     exp_alert;

    lidar_scan_top #(
        .CLKS_PER_BIT(TB_CLKS_PER_BIT)
    ) DUT (
        .clk         (clk),
        .TxD_reset   (TxD_reset),
        .serial_in   (serial_in),
        .result_valid(result_valid),
        .min_angle   (min_angle),
        .max_angle   (max_angle),
        .obs_alert   (obs_alert)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // expected values of the result that comes next
    assign exp_min   = exp_min_tab[results_seen];
    assign exp_max   = exp_max_tab[results_seen];
    assign exp_alert = exp_alert_tab[results_seen];

    always @(posedge clk) begin
        if (TxD_reset) begin
            results_seen <= 4'd0;
        end else if (result_valid) begin
            results_seen <= results_seen + 4'd1;
        end
    end

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] want);
        $display("FAILED %s: got 0x%h expected 0x%h", name, got, want);
        $display("sim failed");
        $fatal(1, "output mismatch");
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "run aborted");
    endtask

    a_min_angle: assert property (
        @(posedge clk) disable iff (TxD_reset) result_valid |-> (min_angle == exp_min)
    ) else report_mismatch("min_angle", $sampled(min_angle), $sampled(exp_min));

    a_max_angle: assert property (
        @(posedge clk) disable iff (TxD_reset) result_valid |-> (max_angle == exp_max)
    ) else report_mismatch("max_angle", $sampled(max_angle), $sampled(exp_max));

    a_obs_alert: assert property (
        @(posedge clk) disable iff (TxD_reset) result_valid |-> (obs_alert == exp_alert)
    ) else report_mismatch("obs_alert", $sampled(obs_alert), $sampled(exp_alert));

    // a result needs a complete valid packet behind it
    a_result_expected: assert property (
        @(posedge clk) disable iff (TxD_reset) result_valid |-> (results_seen < expected_count)
    ) else abort_run("result_valid came without a complete valid packet");

    a_quiet_in_reset: assert property (
        @(posedge clk) TxD_reset |-> !result_valid
    ) else abort_run("result_valid was high during reset");

    function automatic angle_t interp_angle(input angle_t fsa, input angle_t lsa,
                                            input count_t ct, input count_t idx);
        logic [31:0] span;
        logic [31:0] quot;
        span = {16'h0000, lsa - fsa};
        quot = ({24'h000000, idx} * span) / {24'h000000, ct - 8'd1};
        return fsa + quot[15:0];
    endfunction

    task automatic record_expected(input count_t ct, input angle_t fsa, input angle_t lsa);
        dist_t  lo;
        dist_t  hi;
        count_t lo_idx;
        count_t hi_idx;
        alert_t bits;
        lo     = 16'hFFFF;
        hi     = 16'h0000;
        lo_idx = 8'h00;
        hi_idx = 8'h00;
        bits   = 16'h0000;
        for (int i = 0; i < int'(ct); i++) begin
            // zero means no return
            if (samples[i] != 16'h0000) begin
                if (samples[i] < lo) begin
                    lo     = samples[i];
                    lo_idx = count_t'(i);
                end
                if (samples[i] > hi) begin
                    hi     = samples[i];
                    hi_idx = count_t'(i);
                end
                if (i < `LIDAR_ALERT_SAMPLES) begin
                    bits = {samples[i] < `LIDAR_OBS_DISTANCE, bits[15:1]};
                end
            end
        end
        exp_min_tab[expected_count]   = interp_angle(fsa, lsa, ct, lo_idx);
        exp_max_tab[expected_count]   = interp_angle(fsa, lsa, ct, hi_idx);
        exp_alert_tab[expected_count] = bits;
    endtask

    // one bit period with the line changed on the falling edge
    task automatic send_bit(input logic b);
        @(negedge clk);
        serial_in = b;
        repeat (TB_CLKS_PER_BIT - 1) @(negedge clk);
    endtask

    task automatic send_byte(input byte_t b);
        send_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            send_bit(b[i]);
        end
        send_bit(1'b1);
    endtask

    task automatic fill_random(input count_t ct, input logic allow_zero);
        int unsigned pick;
        for (int i = 0; i < int'(ct); i++) begin
            pick = $urandom_range(0, 7);
            if (allow_zero && pick == 0) begin
                samples[i] = 16'h0000;
            end else if (pick < 3) begin
                samples[i] = dist_t'($urandom_range(1, 16'h03FF));
            end else begin
                samples[i] = dist_t'($urandom_range(1, 16'hFFFF));
            end
        end
    endtask

    task automatic send_packet(input count_t ct, input angle_t fsa, input angle_t lsa);
        record_expected(ct, fsa, lsa);
        send_byte(`LIDAR_HEADER_A);
        send_byte(`LIDAR_HEADER_B);
        send_byte(ct);
        send_byte(fsa[7:0]);
        send_byte(fsa[15:8]);
        send_byte(lsa[7:0]);
        send_byte(lsa[15:8]);
        for (int i = 0; i < int'(ct); i++) begin
            send_byte(samples[i][7:0]);
            send_byte(samples[i][15:8]);
        end
        expected_count = expected_count + 4'd1;
    endtask

    task automatic send_random_packet(input logic allow_zero);
        count_t ct;
        ct = count_t'($urandom_range(2, CT_MAX));
        fill_random(ct, allow_zero);
        send_packet(ct, angle_t'($urandom()), angle_t'($urandom()));
    endtask

    // header fine but sample count rejected
    task automatic send_short_count(input count_t ct);
        send_byte(`LIDAR_HEADER_A);
        send_byte(`LIDAR_HEADER_B);
        send_byte(ct);
        send_byte(8'h00);
        send_byte(8'h01);
        send_byte(8'h00);
        send_byte(8'h02);
        send_byte(8'h34);
        send_byte(8'h12);
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("no result within the expected time");
    end

    initial begin
        int unsigned seed_val;
        seed_val       = $urandom(SEED);
        serial_in      = 1'b1;
        TxD_reset      = 1'b1;
        expected_count = 4'd0;
        repeat (8) @(negedge clk);
        TxD_reset = 1'b0;
        repeat (4) @(negedge clk);

        fill_random(8'd10, 1'b0);
        send_packet(8'd10, 16'h0100, 16'h2300);

        for (int i = 0; i < 20; i++) begin
            samples[i] = FIXED_SAMPLES[i];
        end
        send_packet(8'd20, 16'h1000, 16'h3400);

        for (int i = 0; i < 13; i++) begin
            send_byte(BAD_HEADER_PKT[i]);
        end
        send_random_packet(1'b0);

        send_short_count(8'd1);
        send_random_packet(1'b0);
        send_short_count(8'd0);
        send_random_packet(1'b0);

        // back-to-back packets whose spans may wrap
        for (int p = 0; p < BURST_PACKETS; p++) begin
            send_random_packet(1'b1);
        end

        while (results_seen != expected_count) begin
            @(posedge clk);
        end
        repeat (200) @(negedge clk);
        if (results_seen == expected_count) begin
            $display("sim passed");
            $finish;
        end else begin
            abort_run("more results than valid packets sent");
        end
    end

endmodule

`default_nettype wire

// ==== lidar_scan_top.f ====
+incdir+.
lidar_pkg.sv
scan_if.sv
baud_timer.sv
uart_rx.sv
packet_fsm.sv
scan_stats.sv
angle_divider.sv
lidar_scan_top.sv
lidar_scan_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the lidar scan testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module lidar_scan_tb \
    -f lidar_scan_top.f -o lidar_sim || { echo "build failed"; exit 1; }

./obj_dir/lidar_sim 2>&1 | tee sim.log

grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "sim passed" sim.log || { echo "FAIL: run ended early"; exit 1; }
echo "PASS"
